/* Makefile */
VERILATOR := verilator
VFLAGS := --binary --timing --assert
TOP := tb_load_unit
FILELIST := load_unit.f
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: help test clean

help:
	@echo "available targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* load_unit.f */
source/load_pkg.sv
source/rs_entry_if.sv
source/load_alloc.sv
source/load_rs_entry.sv
source/load_select_mem.sv
source/load_unit.sv
testbench/tb_axil_mem.sv
testbench/tb_load_unit.sv

/* source/load_alloc.sv */
`timescale 1ns/1ns
`default_nettype none

module load_alloc
  import load_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic issue_valid,
  output logic issue_ready,
  input load_kind_t issue_kind,
  input word_t issue_imm,
  input rob_tag_t issue_rob,
  input logic issue_base_ready,
  input word_t issue_base,
  input rob_tag_t issue_base_tag,
  rs_entry_if.alloc_mp ent [RS_ENTRIES]
);

  logic [RS_ENTRIES-1:0] free;
  logic [RS_ENTRIES-1:0] lowest_free;
  logic [RS_ENTRIES-1:0] grant;

  // gather busy flags, hand the payload only to the granted entry
  for (genvar g = 0; g < RS_ENTRIES; g++) begin : g_ent
    assign free[g] = !ent[g].busy;
    assign ent[g].alloc = grant[g];
    assign ent[g].alloc_kind = grant[g] ? issue_kind : '0;
    assign ent[g].alloc_imm = grant[g] ? issue_imm : '0;
    assign ent[g].alloc_rob = grant[g] ? issue_rob : '0;
    assign ent[g].alloc_base_ready = grant[g] & issue_base_ready;
    assign ent[g].alloc_base = grant[g] ? issue_base : '0;
    assign ent[g].alloc_base_tag = grant[g] ? issue_base_tag : '0;
  end

  // isolate lowest set bit of the free vector
  always_comb begin
    lowest_free = free & (~free + 1'b1);
  end

  always_comb begin
    issue_ready = |free;
    grant = issue_valid ? lowest_free : '0;
  end

  // at most one entry written per issue
  a_alloc_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(grant)
  );

endmodule

`default_nettype wire

/* source/load_pkg.sv */
`default_nettype none

package load_pkg;

  // reservation station and CDB sizing
  localparam int RS_ENTRIES = 4;
  localparam int CDB_PORTS = 2;
  localparam int ROB_TAG_W = 4;
  localparam int RS_IDX_W = $clog2(RS_ENTRIES);

  // data and address word
  typedef logic [31:0] word_t;

  typedef logic [ROB_TAG_W-1:0] rob_tag_t;

  // entry index, wraps naturally for round robin
  typedef logic [RS_IDX_W-1:0] rs_idx_t;

  // funct3 field of a load
  typedef logic [2:0] load_kind_t;

  // RV32I load funct3 encodings
  localparam load_kind_t LD_B = 3'b000;
  localparam load_kind_t LD_H = 3'b001;
  localparam load_kind_t LD_W = 3'b010;
  localparam load_kind_t LD_BU = 3'b100;
  localparam load_kind_t LD_HU = 3'b101;

  // selector FSM
  typedef enum logic [1:0] {
    SEL_IDLE,
    SEL_ADDR,
    SEL_RESP,
    SEL_DRAIN
  } sel_state_t;

endpackage

`default_nettype wire

/* source/load_rs_entry.sv */
`timescale 1ns/1ns
`default_nettype none

module load_rs_entry
  import load_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic flush,
  input logic [CDB_PORTS-1:0] cdb_valid,
  input rob_tag_t [CDB_PORTS-1:0] cdb_tag,
  input word_t [CDB_PORTS-1:0] cdb_data,
  rs_entry_if.entry_mp ent
);

  logic busy;
  logic ready;
  load_kind_t kind;
  word_t imm;
  rob_tag_t rob;
  word_t base;
  rob_tag_t wait_tag;

  rob_tag_t look_tag;
  logic cdb_hit;
  word_t cdb_val;

  // on alloc the incoming tag is compared, otherwise the stored one
  always_comb begin
    look_tag = ent.alloc ? ent.alloc_base_tag : wait_tag;
    cdb_hit = 1'b0;
    cdb_val = '0;
    for (int p = 0; p < CDB_PORTS; p++) begin
      if (cdb_valid[p] && cdb_tag[p] == look_tag) begin
        cdb_hit = 1'b1;
        cdb_val = cdb_data[p];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      busy <= 1'b0;
      ready <= 1'b0;
    end else if (ent.alloc) begin
      busy <= 1'b1;
      ready <= ent.alloc_base_ready || cdb_hit;
    end else if (ent.pop) begin
      busy <= 1'b0;
      ready <= 1'b0;
    end else if (busy && !ready && cdb_hit) begin
      // wake up
      ready <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ent.alloc) begin
      kind <= ent.alloc_kind;
      imm <= ent.alloc_imm;
      rob <= ent.alloc_rob;
      wait_tag <= ent.alloc_base_tag;
      base <= ent.alloc_base_ready ? ent.alloc_base : cdb_val;
    end else if (busy && !ready && cdb_hit) begin
      base <= cdb_val;
    end
  end

  assign ent.busy = busy;
  assign ent.ready = ready;
  assign ent.kind = kind;
  assign ent.imm = imm;
  assign ent.rob = rob;
  assign ent.base = base;

  // allocator must never pick an occupied entry
  a_no_alloc_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    ent.alloc |-> !busy
  );

  // selector only pops entries it found ready
  a_pop_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
    ent.pop |-> ready
  );

endmodule

`default_nettype wire

/* source/load_select_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module load_select_mem
  import load_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic flush,
  rs_entry_if.select_mp ent [RS_ENTRIES],
  output word_t araddr,
  output logic [2:0] arprot,
  output logic arvalid,
  input logic arready,
  input word_t rdata,
  input logic [1:0] rresp,
  input logic rvalid,
  output logic rready,
  output logic load_valid,
  output rob_tag_t load_rob,
  output word_t load_data,
  output logic load_err
);

  sel_state_t state;
  rs_idx_t rr_ptr;

  // load in flight
  rs_idx_t cur_idx;
  rob_tag_t cur_rob;
  load_kind_t cur_kind;
  logic [1:0] cur_off;

  logic [RS_ENTRIES-1:0] req;
  logic [RS_ENTRIES-1:0] pop_vec;
  load_kind_t kind_arr [RS_ENTRIES];
  word_t imm_arr [RS_ENTRIES];
  rob_tag_t rob_arr [RS_ENTRIES];
  word_t base_arr [RS_ENTRIES];

  logic pick_valid;
  rs_idx_t pick_idx;
  word_t pick_addr;
  logic r_done;
  logic [7:0] sel_byte;
  logic [15:0] sel_half;
  word_t ext_data;

  for (genvar g = 0; g < RS_ENTRIES; g++) begin : g_ent
    assign req[g] = ent[g].busy && ent[g].ready;
    assign kind_arr[g] = ent[g].kind;
    assign imm_arr[g] = ent[g].imm;
    assign rob_arr[g] = ent[g].rob;
    assign base_arr[g] = ent[g].base;
    assign ent[g].pop = pop_vec[g];
  end

  // round robin from rr_ptr, closest ready entry wins
  always_comb begin
    rs_idx_t idx;
    pick_valid = 1'b0;
    pick_idx = rr_ptr;
    for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
      idx = rr_ptr + rs_idx_t'(i);
      if (req[idx]) begin
        pick_valid = 1'b1;
        pick_idx = idx;
      end
    end
    pick_addr = base_arr[pick_idx] + imm_arr[pick_idx];
  end

  assign arprot = 3'b000;
  assign rready = (state == SEL_RESP) || (state == SEL_DRAIN && !arvalid);
  assign r_done = (state == SEL_RESP) && rvalid;
  assign pop_vec = (r_done && !flush) ? (RS_ENTRIES'(1) << cur_idx) : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= SEL_IDLE;
      rr_ptr <= '0;
      arvalid <= 1'b0;
      load_valid <= 1'b0;
    end else begin
      load_valid <= 1'b0;
      case (state)
        SEL_IDLE: begin
          if (pick_valid && !flush) begin
            state <= SEL_ADDR;
            arvalid <= 1'b1;
          end
        end
        SEL_ADDR: begin
          if (arready) begin
            arvalid <= 1'b0;
            state <= flush ? SEL_DRAIN : SEL_RESP;
          end else if (flush) begin
            // keep the request up, AXI does not allow withdrawing it
            state <= SEL_DRAIN;
          end
        end
        SEL_RESP: begin
          if (rvalid) begin
            state <= SEL_IDLE;
            if (!flush) begin
              load_valid <= 1'b1;
              rr_ptr <= cur_idx + 1'b1;
            end
          end else if (flush) begin
            state <= SEL_DRAIN;
          end
        end
        SEL_DRAIN: begin
          if (arvalid && arready) begin
            arvalid <= 1'b0;
          end
          // response swallowed, no result
          if (!arvalid && rvalid) begin
            state <= SEL_IDLE;
          end
        end
        default: state <= SEL_IDLE;
      endcase
    end
  end

  // latch the chosen entry
  always_ff @(posedge clk) begin
    if (state == SEL_IDLE && pick_valid) begin
      cur_idx <= pick_idx;
      cur_rob <= rob_arr[pick_idx];
      cur_kind <= kind_arr[pick_idx];
      cur_off <= pick_addr[1:0];
      araddr <= {pick_addr[31:2], 2'b00};
    end
  end

  // byte / half lane select and extension
  always_comb begin
    sel_byte = rdata[{cur_off, 3'b000} +: 8];
    sel_half = rdata[{cur_off[1], 4'b0000} +: 16];
    case (cur_kind)
      LD_B: ext_data = {{24{sel_byte[7]}}, sel_byte};
      LD_BU: ext_data = {24'b0, sel_byte};
      LD_H: ext_data = {{16{sel_half[15]}}, sel_half};
      LD_HU: ext_data = {16'b0, sel_half};
      LD_W: ext_data = rdata;
      default: ext_data = rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (r_done) begin
      load_rob <= cur_rob;
      load_data <= ext_data;
      load_err <= (rresp != 2'b00);
    end
  end

  a_araddr_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (arvalid && !arready) |=> (arvalid && $stable(araddr))
  );

  a_result_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    load_valid |=> !load_valid
  );

endmodule

`default_nettype wire

/* source/load_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module load_unit
  import load_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic flush,

  // issue stage
  input logic issue_valid,
  output logic issue_ready,
  input load_kind_t issue_kind,
  input word_t issue_imm,
  input rob_tag_t issue_rob,
  input logic issue_base_ready,
  input word_t issue_base,
  input rob_tag_t issue_base_tag,

  // common data bus snoop
  input logic [CDB_PORTS-1:0] cdb_valid,
  input rob_tag_t [CDB_PORTS-1:0] cdb_tag,
  input word_t [CDB_PORTS-1:0] cdb_data,

  // AXI4-Lite read
  output word_t araddr,
  output logic [2:0] arprot,
  output logic arvalid,
  input logic arready,
  input word_t rdata,
  input logic [1:0] rresp,
  input logic rvalid,
  output logic rready,

  // result broadcast
  output logic load_valid,
  output rob_tag_t load_rob,
  output word_t load_data,
  output logic load_err
);

  rs_entry_if ent_if [RS_ENTRIES] ();

  load_alloc i_alloc (
    .clk(clk),
    .rst_n(rst_n),
    .issue_valid(issue_valid),
    .issue_ready(issue_ready),
    .issue_kind(issue_kind),
    .issue_imm(issue_imm),
    .issue_rob(issue_rob),
    .issue_base_ready(issue_base_ready),
    .issue_base(issue_base),
    .issue_base_tag(issue_base_tag),
    .ent(ent_if)
  );

  // reservation entries
  for (genvar g = 0; g < RS_ENTRIES; g++) begin : g_rs
    load_rs_entry i_entry (
      .clk(clk),
      .rst_n(rst_n),
      .flush(flush),
      .cdb_valid(cdb_valid),
      .cdb_tag(cdb_tag),
      .cdb_data(cdb_data),
      .ent(ent_if[g])
    );
  end

  load_select_mem i_select (
    .clk(clk),
    .rst_n(rst_n),
    .flush(flush),
    .ent(ent_if),
    .araddr(araddr),
    .arprot(arprot),
    .arvalid(arvalid),
    .arready(arready),
    .rdata(rdata),
    .rresp(rresp),
    .rvalid(rvalid),
    .rready(rready),
    .load_valid(load_valid),
    .load_rob(load_rob),
    .load_data(load_data),
    .load_err(load_err)
  );

endmodule

`default_nettype wire

/* source/rs_entry_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface rs_entry_if
  import load_pkg::*;
();

  // allocation strobe and payload
  logic alloc;
  load_kind_t alloc_kind;
  word_t alloc_imm;
  rob_tag_t alloc_rob;
  logic alloc_base_ready;
  word_t alloc_base;
  rob_tag_t alloc_base_tag;

  // entry status
  logic busy;
  logic ready;
  load_kind_t kind;
  word_t imm;
  rob_tag_t rob;
  word_t base;

  // selector done with this entry
  logic pop;

  modport alloc_mp (
    output alloc, alloc_kind, alloc_imm, alloc_rob,
    output alloc_base_ready, alloc_base, alloc_base_tag,
    input busy
  );

  modport entry_mp (
    input alloc, alloc_kind, alloc_imm, alloc_rob,
    input alloc_base_ready, alloc_base, alloc_base_tag,
    input pop,
    output busy, ready, kind, imm, rob, base
  );

  modport select_mp (
    input busy, ready, kind, imm, rob, base,
    output pop
  );

endinterface

`default_nettype wire

/* testbench/tb_axil_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_axil_mem
  import load_pkg::*;
#(
  parameter word_t PATTERN = 32'h0,
  parameter word_t ERR_BASE = 32'h0000_f000
) (
  input logic clk,
  input logic rst_n,
  input logic slow_resp,
  input word_t araddr,
  input logic arvalid,
  output logic arready,
  output word_t rdata,
  output logic [1:0] rresp,
  output logic rvalid,
  input logic rready
);

  integer seed;
  int unsigned wait_cnt;
  logic pending;
  logic rst_seen;
  logic slow_seen;
  logic ar_fire;
  logic r_fire;
  logic ar_seen;
  word_t addr_seen;
  word_t addr_q;

  // 0 to 3 cycles of latency
  function automatic int unsigned draw_delay();
    draw_delay = $unsigned($random(seed)) % 4;
  endfunction

  // inputs sampled mid-cycle, outputs driven just after the rising edge
  initial begin
    seed = 32'h12cc;
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = '0;
    rresp = 2'b00;
    pending = 1'b0;
    addr_q = '0;
    wait_cnt = draw_delay();
    forever begin
      @(negedge clk);
      rst_seen = rst_n;
      slow_seen = slow_resp;
      ar_fire = arvalid && arready;
      r_fire = rvalid && rready;
      ar_seen = arvalid;
      addr_seen = araddr;
      @(posedge clk);
      #10;
      if (!rst_seen) begin
        arready = 1'b0;
        rvalid = 1'b0;
        pending = 1'b0;
        wait_cnt = draw_delay();
      end else begin
        if (ar_fire) begin
          arready = 1'b0;
          pending = 1'b1;
          addr_q = addr_seen;
          wait_cnt = draw_delay() + (slow_seen ? 32'd6 : 32'd0);
        end else if (!pending && ar_seen && !arready) begin
          if (wait_cnt == 0) arready = 1'b1;
          else wait_cnt--;
        end
        if (r_fire) begin
          rvalid = 1'b0;
          pending = 1'b0;
          wait_cnt = draw_delay();
        end else if (pending && !rvalid && !ar_fire) begin
          if (wait_cnt == 0) begin
            rvalid = 1'b1;
            // word address xor pattern, slave error above ERR_BASE
            rdata = {2'b00, addr_q[31:2]} ^ PATTERN;
            rresp = (addr_q >= ERR_BASE) ? 2'b10 : 2'b00;
          end else begin
            wait_cnt--;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_load_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_load_unit
  import load_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam word_t MEM_PATTERN = 32'h7a5f_c31e;
  localparam int LOAD_COUNT = 25;
  localparam int WATCHDOG_CYCLES = LOAD_COUNT * 20 + 200;

  logic clk;
  logic rst_n;
  logic flush;
  logic issue_valid;
  logic issue_ready;
  load_kind_t issue_kind;
  word_t issue_imm;
  rob_tag_t issue_rob;
  logic issue_base_ready;
  word_t issue_base;
  rob_tag_t issue_base_tag;
  logic [CDB_PORTS-1:0] cdb_valid;
  rob_tag_t [CDB_PORTS-1:0] cdb_tag;
  word_t [CDB_PORTS-1:0] cdb_data;
  word_t araddr;
  logic [2:0] arprot;
  logic arvalid;
  logic arready;
  word_t rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  logic load_valid;
  rob_tag_t load_rob;
  word_t load_data;
  logic load_err;
  logic slow_resp;

  rob_tag_t next_rob;
  rob_tag_t res_rob [$];
  word_t res_data [$];
  logic res_err [$];

  load_unit i_dut (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .issue_valid(issue_valid), .issue_ready(issue_ready), .issue_kind(issue_kind),
    .issue_imm(issue_imm), .issue_rob(issue_rob), .issue_base_ready(issue_base_ready),
    .issue_base(issue_base), .issue_base_tag(issue_base_tag),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
    .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .load_valid(load_valid), .load_rob(load_rob), .load_data(load_data),
    .load_err(load_err)
  );

  tb_axil_mem #(.PATTERN(MEM_PATTERN)) i_mem (
    .clk(clk), .rst_n(rst_n), .slow_resp(slow_resp),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // result monitor
  always @(negedge clk) begin
    if (rst_n && load_valid) begin
      res_rob.push_back(load_rob);
      res_data.push_back(load_data);
      res_err.push_back(load_err);
    end
  end

  task automatic abort_run(string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  function automatic rob_tag_t take_rob();
    take_rob = next_rob;
    next_rob = next_rob + 4'd1;
  endfunction

  // memory word is word address xor pattern, then lane pick and extension
  function automatic word_t expected_load(load_kind_t kind, word_t addr);
    word_t w;
    word_t lane;
    w = {2'b00, addr[31:2]} ^ MEM_PATTERN;
    lane = w >> {addr[1:0], 3'b000};
    case (kind)
      LD_B: expected_load = {{24{lane[7]}}, lane[7:0]};
      LD_BU: expected_load = {24'h0, lane[7:0]};
      LD_H: expected_load = {{16{lane[15]}}, lane[15:0]};
      LD_HU: expected_load = {16'h0, lane[15:0]};
      default: expected_load = w;
    endcase
  endfunction

  // holds issue_valid until the handshake edge has passed
  task automatic issue_load(load_kind_t kind, word_t imm, rob_tag_t rob,
                            logic base_ready, word_t base, rob_tag_t base_tag);
    int n;
    issue_valid = 1'b1;
    issue_kind = kind;
    issue_imm = imm;
    issue_rob = rob;
    issue_base_ready = base_ready;
    issue_base = base;
    issue_base_tag = base_tag;
    n = 0;
    @(negedge clk);
    while (!issue_ready) begin
      if (n > 50) abort_run("issue was never accepted");
      n++;
      @(negedge clk);
    end
    next_cycle();
    issue_valid = 1'b0;
  endtask

  task automatic broadcast_cdb(int port, rob_tag_t tag, word_t data);
    cdb_valid[port] = 1'b1;
    cdb_tag[port] = tag;
    cdb_data[port] = data;
    next_cycle();
    cdb_valid[port] = 1'b0;
  endtask

  task automatic wait_for_result();
    int n;
    n = 0;
    while (res_rob.size() == 0) begin
      if (n > 60) abort_run("no load result arrived in time");
      next_cycle();
      n++;
    end
  endtask

  task automatic await_result(rob_tag_t rob, word_t data, logic err, logic check_data);
    word_t got_data;
    wait_for_result();
    compare_value("load_rob", 32'(res_rob.pop_front()), 32'(rob));
    got_data = res_data.pop_front();
    compare_value("load_err", 32'(res_err.pop_front()), 32'(err));
    if (check_data) compare_value("load_data", got_data, data);
  endtask

  // selector idle: arvalid rises one edge after the entry becomes ready
  task automatic run_ready_load(load_kind_t kind, word_t base, word_t imm, logic err);
    word_t addr;
    rob_tag_t rob;
    addr = base + imm;
    rob = take_rob();
    issue_load(kind, imm, rob, 1'b1, base, 4'd0);
    @(negedge clk);
    compare_value("arvalid", 32'(arvalid), 32'h0);
    @(negedge clk);
    compare_value("arvalid", 32'(arvalid), 32'h1);
    compare_value("araddr", araddr, {addr[31:2], 2'b00});
    compare_value("arprot", 32'(arprot), 32'h0);
    next_cycle();
    await_result(rob, expected_load(kind, addr), err, !err);
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    compare_value("issue_ready", 32'(issue_ready), 32'h1);
    compare_value("arvalid", 32'(arvalid), 32'h0);
    compare_value("rready", 32'(rready), 32'h0);
    compare_value("load_valid", 32'(load_valid), 32'h0);
    next_cycle();
  endtask

  task automatic sweep_widths();
    for (int off = 0; off < 4; off++) begin
      run_ready_load(LD_B, 32'h0000_0100 + 32'(off * 16), 32'(off), 1'b0);
      run_ready_load(LD_BU, 32'h0000_0184 + 32'(off * 8), 32'(off), 1'b0);
    end
    for (int off = 0; off < 4; off += 2) begin
      run_ready_load(LD_H, 32'h0000_0300, 32'(off + 8), 1'b0);
      run_ready_load(LD_HU, 32'h0000_0340, 32'(off), 1'b0);
    end
    run_ready_load(LD_W, 32'h0000_0210, 32'hffff_fffc, 1'b0);
  endtask

  task automatic cdb_wakeup();
    rob_tag_t rob;
    rob = take_rob();
    issue_load(LD_H, 32'h6, rob, 1'b0, 32'hdead_beec, 4'd9);
    repeat (5) begin
      @(negedge clk);
      compare_value("arvalid", 32'(arvalid), 32'h0);
    end
    next_cycle();
    broadcast_cdb(1, 4'd9, 32'h0000_0440);
    await_result(rob, expected_load(LD_H, 32'h0000_0446), 1'b0, 1'b1);
    // base arrives on the CDB at the issue edge itself
    rob = take_rob();
    cdb_valid[0] = 1'b1;
    cdb_tag[0] = 4'd3;
    cdb_data[0] = 32'h0000_0450;
    issue_load(LD_BU, 32'h3, rob, 1'b0, 32'h0, 4'd3);
    cdb_valid = '0;
    await_result(rob, expected_load(LD_BU, 32'h0000_0453), 1'b0, 1'b1);
  endtask

  task automatic fill_and_reorder();
    rob_tag_t robs [4];
    word_t bases [4];
    load_kind_t kinds [4];
    word_t imms [4];
    word_t exp_by_tag [16];
    logic waiting [16];
    rob_tag_t got;
    kinds = '{LD_W, LD_B, LD_HU, LD_BU};
    imms = '{32'h8, 32'h1, 32'h2, 32'h7};
    for (int i = 0; i < 16; i++) begin
      waiting[i] = 1'b0;
      exp_by_tag[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      robs[i] = take_rob();
      bases[i] = 32'h0000_0800 + 32'(i * 32);
      exp_by_tag[robs[i]] = expected_load(kinds[i], bases[i] + imms[i]);
      waiting[robs[i]] = 1'b1;
      issue_load(kinds[i], imms[i], robs[i], 1'b0, 32'h0, rob_tag_t'(10 + i));
    end
    @(negedge clk);
    compare_value("issue_ready", 32'(issue_ready), 32'h0);
    next_cycle();
    // wake in reverse order, alternating CDB ports
    for (int i = 3; i >= 0; i--) begin
      broadcast_cdb(i % 2, rob_tag_t'(10 + i), bases[i]);
    end
    for (int k = 0; k < 4; k++) begin
      wait_for_result();
      got = res_rob.pop_front();
      if (!waiting[got]) abort_run("result carried an unexpected or repeated ROB tag");
      waiting[got] = 1'b0;
      compare_value("load_data", res_data.pop_front(), exp_by_tag[got]);
      compare_value("load_err", 32'(res_err.pop_front()), 32'h0);
    end
  endtask

  task automatic error_response();
    run_ready_load(LD_W, 32'h0000_f000, 32'h10, 1'b1);
  endtask

  task automatic flush_inflight();
    int n;
    slow_resp = 1'b1;
    // one read in flight while the other three entries wait on the CDB
    issue_load(LD_W, 32'h4, take_rob(), 1'b1, 32'h0000_0a00, 4'd0);
    for (int i = 0; i < 3; i++) begin
      issue_load(LD_W, 32'(i * 4), take_rob(), 1'b0, 32'h0, rob_tag_t'(12 + i));
    end
    n = 0;
    @(negedge clk);
    compare_value("issue_ready", 32'(issue_ready), 32'h0);
    while (!rready) begin
      if (n > 30) abort_run("read never reached the response phase");
      n++;
      @(negedge clk);
    end
    next_cycle();
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    slow_resp = 1'b0;
    // drained response must be taken by the DUT
    n = 0;
    @(negedge clk);
    while (!(rvalid && rready)) begin
      if (n > 30) abort_run("flushed read response was never drained");
      n++;
      @(negedge clk);
    end
    next_cycle();
    for (int i = 0; i < 3; i++) begin
      broadcast_cdb(i % 2, rob_tag_t'(12 + i), 32'h0000_0b00);
    end
    repeat (6) next_cycle();
    compare_value("flushed result count", 32'(res_rob.size()), 32'h0);
    @(negedge clk);
    compare_value("issue_ready", 32'(issue_ready), 32'h1);
    next_cycle();
    run_ready_load(LD_HU, 32'h0000_0c00, 32'h2, 1'b0);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    flush = 1'b0;
    issue_valid = 1'b0;
    issue_kind = LD_W;
    issue_imm = '0;
    issue_rob = '0;
    issue_base_ready = 1'b0;
    issue_base = '0;
    issue_base_tag = '0;
    cdb_valid = '0;
    cdb_tag = '0;
    cdb_data = '0;
    slow_resp = 1'b0;
    next_rob = '0;
    repeat (8) @(posedge clk);
    #10;
    rst_n = 1'b1;
    check_reset_state();
    sweep_widths();
    cdb_wakeup();
    fill_and_reorder();
    error_response();
    flush_inflight();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire
